// File: isa_pkg.sv
// Instruction set definitions for the 8-bit accumulator processor
// Opcode encodings, ALU operation codes and architectural widths
`default_nettype none

package isa_pkg;

    localparam int data_w = 8;                 // Data bus and register width
    localparam int addr_w = 16;                // Architectural address width

    localparam logic [7:0] op_nop    = 8'h00;
    localparam logic [7:0] op_ldai   = 8'h01;  // Immediate loads
    localparam logic [7:0] op_ldbi   = 8'h02;
    localparam logic [7:0] op_ldhi   = 8'h03;
    localparam logic [7:0] op_ldli   = 8'h04;
    localparam logic [7:0] op_lda_hl = 8'h05;  // Indirect through H:L
    localparam logic [7:0] op_sta_hl = 8'h06;
    localparam logic [7:0] op_add    = 8'h10;  // ALU group puts A op B into A
    localparam logic [7:0] op_sub    = 8'h11;
    localparam logic [7:0] op_and    = 8'h12;
    localparam logic [7:0] op_or     = 8'h13;
    localparam logic [7:0] op_xor    = 8'h14;
    localparam logic [7:0] op_mov_ab = 8'h20;  // Register moves
    localparam logic [7:0] op_mov_ba = 8'h21;
    localparam logic [7:0] op_mov_ah = 8'h22;
    localparam logic [7:0] op_mov_al = 8'h23;
    localparam logic [7:0] op_jmp    = 8'h30;  // Address high byte then low byte follow
    localparam logic [7:0] op_jz     = 8'h31;
    localparam logic [7:0] op_halt   = 8'hFF;

    localparam logic [2:0] alu_add = 3'd0;
    localparam logic [2:0] alu_sub = 3'd1;
    localparam logic [2:0] alu_and = 3'd2;
    localparam logic [2:0] alu_or  = 3'd3;
    localparam logic [2:0] alu_xor = 3'd4;

endpackage

`default_nettype wire

// File: uarch_pkg.sv
// Microarchitecture constants for the accumulator processor
// Stage counter size and memory geometry
`default_nettype none

package uarch_pkg;

    // Longest instruction takes four stages
    localparam int stage_w = 2;

    localparam int mem_aw    = 8;             // Low address bits seen by memory
    localparam int mem_depth = 256;           // Bytes of shared memory

endpackage

`default_nettype wire

// File: alu.sv
// Arithmetic and logic unit
// Latches its operation in the first stage of an ALU instruction and
// forms A op B combinationally from then on
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire logic                        clk,
    input  wire logic                        ireg_reset,
    input  wire logic                        alu_op_load,
    input  wire logic [2:0]                  alu_op,
    input  wire logic [isa_pkg::data_w-1:0]  a_q,
    input  wire logic [isa_pkg::data_w-1:0]  b_q,
    output logic      [isa_pkg::data_w-1:0]  result
);

    logic [2:0] op_q;                                   // Held operation code

    always_ff @(posedge clk) begin
        if (ireg_reset) begin
            op_q <= isa_pkg::alu_add;
        end else if (alu_op_load) begin
            op_q <= alu_op;
        end
    end

    always_comb begin
        case (op_q)
            isa_pkg::alu_add: result = a_q + b_q;       // Carry out dropped
            isa_pkg::alu_sub: result = a_q - b_q;       // Wraps modulo 256
            isa_pkg::alu_and: result = a_q & b_q;
            isa_pkg::alu_or:  result = a_q | b_q;
            isa_pkg::alu_xor: result = a_q ^ b_q;
            default:          result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: bus_select.sv
// Data bus selector
// Fixed-priority pick of the single source driving the shared data bus;
// the bus reads zero when no source is enabled
`timescale 1ns/1ps
`default_nettype none

module bus_select (
    input  wire logic [isa_pkg::data_w-1:0]  a_q,
    input  wire logic [isa_pkg::data_w-1:0]  b_q,
    input  wire logic [isa_pkg::data_w-1:0]  h_q,
    input  wire logic [isa_pkg::data_w-1:0]  l_q,
    input  wire logic [isa_pkg::data_w-1:0]  result,
    input  wire logic [isa_pkg::data_w-1:0]  mem_rdata,
    input  wire logic                        a_out,
    input  wire logic                        b_out,
    input  wire logic                        h_out,
    input  wire logic                        l_out,
    input  wire logic                        alu_out,
    input  wire logic                        mem_read,
    output logic      [isa_pkg::data_w-1:0]  data_bus
);

    always_comb begin
        if (mem_read)     data_bus = mem_rdata;         // Fetch and operand reads
        else if (alu_out) data_bus = result;
        else if (a_out)   data_bus = a_q;
        else if (b_out)   data_bus = b_q;
        else if (h_out)   data_bus = h_q;
        else if (l_out)   data_bus = l_q;
        else              data_bus = '0;
    end

endmodule

`default_nettype wire

// File: program_counter.sv
// Program counter
// Steps past each fetched byte and takes the memory address register
// on a jump; a jump load wins over an increment
`timescale 1ns/1ps
`default_nettype none

module program_counter (
    input  wire logic                        clk,
    input  wire logic                        ireg_reset,
    input  wire logic                        run,
    input  wire logic                        pc_inc,
    input  wire logic                        pc_load,
    input  wire logic [isa_pkg::addr_w-1:0]  mar_q,
    output logic      [isa_pkg::addr_w-1:0]  pc_q
);

    always_ff @(posedge clk) begin
        if (ireg_reset || !run) begin
            pc_q <= '0;                                 // Programs start at address 0
        end else if (pc_load) begin
            pc_q <= mar_q;
        end else if (pc_inc) begin
            pc_q <= pc_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: register_bank.sv
// Architectural register bank
// A, B, H, L, instruction register and the two-byte memory address
// register, all loaded from the shared data bus, plus the zero flag
`timescale 1ns/1ps
`default_nettype none

module register_bank (
    input  wire logic                        clk,
    input  wire logic                        ireg_reset,
    input  wire logic                        run,
    input  wire logic [isa_pkg::data_w-1:0]  data_bus,
    input  wire logic                        a_load,
    input  wire logic                        b_load,
    input  wire logic                        h_load,
    input  wire logic                        l_load,
    input  wire logic                        ir_load,
    input  wire logic                        mar_h_load,
    input  wire logic                        mar_l_load,
    input  wire logic                        alu_out,
    output logic      [isa_pkg::data_w-1:0]  a_q,
    output logic      [isa_pkg::data_w-1:0]  b_q,
    output logic      [isa_pkg::data_w-1:0]  h_q,
    output logic      [isa_pkg::data_w-1:0]  l_q,
    output logic      [7:0]                  opcode,
    output logic      [isa_pkg::addr_w-1:0]  mar_q,
    output logic                             zero_flag
);

    always_ff @(posedge clk) begin
        if (ireg_reset || !run) begin
            a_q       <= '0;
            b_q       <= '0;
            h_q       <= '0;
            l_q       <= '0;
            opcode    <= isa_pkg::op_nop;               // First cycle with run fetches
            mar_q     <= '0;
            zero_flag <= 1'b0;
        end else begin
            if (a_load) a_q <= data_bus;
            if (b_load) b_q <= data_bus;
            if (h_load) h_q <= data_bus;
            if (l_load) l_q <= data_bus;
            if (ir_load) opcode <= data_bus;
            if (mar_h_load) mar_q[isa_pkg::addr_w-1:isa_pkg::data_w] <= data_bus;
            if (mar_l_load) mar_q[isa_pkg::data_w-1:0] <= data_bus;
            if (a_load && alu_out) begin
                zero_flag <= (data_bus == '0);         // Only ALU results touch Z
            end
        end
    end

endmodule

`default_nettype wire

// File: sequencer.sv
// Instruction sequencer
// Stage counter plus decode of opcode and stage into one cycle of
// control strobes. Every instruction ends in a fetch stage that loads
// the next opcode and clears the stage. HALT parks the machine at stage 0.
`timescale 1ns/1ps
`default_nettype none

module sequencer (
    input  wire logic       clk,
    input  wire logic       ireg_reset,
    input  wire logic       run,
    input  wire logic [7:0] opcode,
    input  wire logic       zero_flag,
    output logic            a_load,
    output logic            b_load,
    output logic            h_load,
    output logic            l_load,
    output logic            a_out,
    output logic            b_out,
    output logic            h_out,
    output logic            l_out,
    output logic            alu_out,
    output logic            alu_op_load,
    output logic [2:0]      alu_op,
    output logic            mar_h_load,
    output logic            mar_l_load,
    output logic            mem_read,
    output logic            mem_write,
    output logic            addr_from_pc,
    output logic            pc_inc,
    output logic            pc_load,
    output logic            ir_load,
    output logic            stage_clear,
    output logic            halted
);

    logic [uarch_pkg::stage_w-1:0] stage;
    logic                          fetch;      // Last stage of every instruction
    logic                          imm;        // Operand byte read at PC
    logic                          take;       // Jump path for JMP and JZ

    assign halted = (opcode == isa_pkg::op_halt);
    assign take   = (opcode == isa_pkg::op_jmp) || zero_flag;

    always_ff @(posedge clk) begin
        if (ireg_reset || !run || stage_clear) begin
            stage <= '0;
        end else if (!halted) begin
            stage <= stage + 1'b1;
        end
    end

    always_comb begin
        {a_load, b_load, h_load, l_load} = 4'b0000;
        {a_out, b_out, h_out, l_out, alu_out} = 5'b00000;
        {mar_h_load, mar_l_load, mem_read, mem_write} = 4'b0000;
        {addr_from_pc, pc_inc, pc_load, ir_load, stage_clear} = 5'b00000;
        alu_op_load = 1'b0;
        alu_op      = isa_pkg::alu_add;
        fetch       = 1'b0;
        imm         = 1'b0;

        case (opcode)
            isa_pkg::op_ldai, isa_pkg::op_ldbi, isa_pkg::op_ldhi, isa_pkg::op_ldli: begin
                if (stage == 0) begin
                    imm    = 1'b1;
                    a_load = (opcode == isa_pkg::op_ldai);
                    b_load = (opcode == isa_pkg::op_ldbi);
                    h_load = (opcode == isa_pkg::op_ldhi);
                    l_load = (opcode == isa_pkg::op_ldli);
                end else begin
                    fetch = 1'b1;
                end
            end
            isa_pkg::op_add, isa_pkg::op_sub, isa_pkg::op_and, isa_pkg::op_or,
            isa_pkg::op_xor: begin
                if (stage == 0) begin
                    alu_op_load = 1'b1;                 // ALU holds op for next stage
                    case (opcode)
                        isa_pkg::op_sub: alu_op = isa_pkg::alu_sub;
                        isa_pkg::op_and: alu_op = isa_pkg::alu_and;
                        isa_pkg::op_or:  alu_op = isa_pkg::alu_or;
                        isa_pkg::op_xor: alu_op = isa_pkg::alu_xor;
                        default:         alu_op = isa_pkg::alu_add;
                    endcase
                end else if (stage == 1) begin
                    alu_out = 1'b1;                     // Result into A and zero flag
                    a_load  = 1'b1;
                end else begin
                    fetch = 1'b1;
                end
            end
            isa_pkg::op_mov_ab, isa_pkg::op_mov_ba, isa_pkg::op_mov_ah,
            isa_pkg::op_mov_al: begin
                if (stage == 0) begin
                    b_out  = (opcode == isa_pkg::op_mov_ba);
                    a_out  = !b_out;
                    a_load = b_out;
                    b_load = (opcode == isa_pkg::op_mov_ab);
                    h_load = (opcode == isa_pkg::op_mov_ah);
                    l_load = (opcode == isa_pkg::op_mov_al);
                end else begin
                    fetch = 1'b1;
                end
            end
            isa_pkg::op_lda_hl, isa_pkg::op_sta_hl: begin
                case (stage)
                    2'd0: {h_out, mar_h_load} = 2'b11;  // MAR high from H
                    2'd1: {l_out, mar_l_load} = 2'b11;  // MAR low from L
                    2'd2: begin
                        mem_read  = (opcode == isa_pkg::op_lda_hl);
                        a_load    = mem_read;
                        a_out     = !mem_read;
                        mem_write = !mem_read;
                    end
                    default: fetch = 1'b1;
                endcase
            end
            isa_pkg::op_jmp, isa_pkg::op_jz: begin
                case (stage)
                    2'd0: begin
                        pc_inc     = 1'b1;              // Skip address byte when not taken
                        imm        = take;
                        mar_h_load = take;
                    end
                    2'd1: begin
                        pc_inc     = 1'b1;
                        imm        = take;
                        mar_l_load = take;
                    end
                    2'd2: begin
                        pc_load = take;
                        fetch   = !take;
                    end
                    default: fetch = 1'b1;
                endcase
            end
            isa_pkg::op_halt: begin
                // Nothing issues and stage stays at 0
            end
            default: fetch = 1'b1;                      // NOP and unused opcodes
        endcase

        if (fetch) begin
            ir_load     = 1'b1;
            stage_clear = 1'b1;
        end
        if (fetch || imm) begin
            mem_read     = 1'b1;
            addr_from_pc = 1'b1;
            pc_inc       = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: shared_ram.sv
// Shared program and data memory
// One write port, owned by the host loader while run is low and by the
// processor while run is high. Two combinational read ports: one for the
// processor and a peek port the host can use at any time.
`timescale 1ns/1ps
`default_nettype none

module shared_ram (
    input  wire logic                          clk,
    input  wire logic                          run,
    input  wire logic                          host_we,
    input  wire logic [uarch_pkg::mem_aw-1:0]  host_addr,
    input  wire logic [isa_pkg::data_w-1:0]    host_wdata,
    input  wire logic [uarch_pkg::mem_aw-1:0]  cpu_addr,
    input  wire logic                          mem_write,
    input  wire logic [isa_pkg::data_w-1:0]    data_bus,
    input  wire logic [uarch_pkg::mem_aw-1:0]  peek_addr,
    output logic      [isa_pkg::data_w-1:0]    mem_rdata,
    output logic      [isa_pkg::data_w-1:0]    peek_data
);

    logic [isa_pkg::data_w-1:0] mem [uarch_pkg::mem_depth];

    always_ff @(posedge clk) begin
        if (run) begin
            if (mem_write) mem[cpu_addr] <= data_bus;   // Processor owns writes
        end else if (host_we) begin
            mem[host_addr] <= host_wdata;               // Loader path
        end
    end

    assign mem_rdata = mem[cpu_addr];
    assign peek_data = mem[peek_addr];

endmodule

`default_nettype wire

// File: cpu_top.sv
// Accumulator processor top level
// Sequencer, register bank, ALU, bus selector and program counter
// around a memory shared with the host loader
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  wire logic                          clk,
    input  wire logic                          ireg_reset,
    input  wire logic                          run,
    input  wire logic                          host_we,
    input  wire logic [uarch_pkg::mem_aw-1:0]  host_addr,
    input  wire logic [isa_pkg::data_w-1:0]    host_wdata,
    input  wire logic [uarch_pkg::mem_aw-1:0]  peek_addr,
    output logic      [isa_pkg::data_w-1:0]    peek_data,
    output logic                               halted
);

    logic [isa_pkg::data_w-1:0]   data_bus;
    logic [isa_pkg::data_w-1:0]   a_q;
    logic [isa_pkg::data_w-1:0]   b_q;
    logic [isa_pkg::data_w-1:0]   h_q;
    logic [isa_pkg::data_w-1:0]   l_q;
    logic [isa_pkg::data_w-1:0]   result;
    logic [isa_pkg::data_w-1:0]   mem_rdata;
    logic [7:0]                   opcode;
    logic [isa_pkg::addr_w-1:0]   mar_q;
    logic [isa_pkg::addr_w-1:0]   pc_q;
    logic [uarch_pkg::mem_aw-1:0] cpu_addr;
    logic [2:0]                   alu_op;
    logic a_load, b_load, h_load, l_load;
    logic a_out, b_out, h_out, l_out, alu_out;
    logic alu_op_load, mar_h_load, mar_l_load;
    logic mem_read, mem_write, addr_from_pc;
    logic pc_inc, pc_load, ir_load, stage_clear;
    logic zero_flag;

    // Memory sees only the low address bits
    assign cpu_addr = addr_from_pc ? pc_q[uarch_pkg::mem_aw-1:0]
                                   : mar_q[uarch_pkg::mem_aw-1:0];

    sequencer u_sequencer (.*);

    register_bank u_register_bank (.*);

    alu u_alu (.*);

    bus_select u_bus_select (.*);

    program_counter u_program_counter (.*);

    shared_ram u_shared_ram (.*);

endmodule

`default_nettype wire

// File: cpu_chk.sv
// Sequencer rule checks
// Single data bus driver, no read and write together, sticky halt
`timescale 1ns/1ps
`default_nettype none

module cpu_chk (
    input wire logic clk,
    input wire logic ireg_reset,
    input wire logic run,
    input wire logic a_out,
    input wire logic b_out,
    input wire logic h_out,
    input wire logic l_out,
    input wire logic alu_out,
    input wire logic mem_read,
    input wire logic mem_write,
    input wire logic halted
);

    assert property (@(posedge clk) disable iff (ireg_reset)
        $onehot0({a_out, b_out, h_out, l_out, alu_out, mem_read}))
        else $error("More than one data bus source enabled");

    assert property (@(posedge clk) disable iff (ireg_reset)
        !(mem_write && mem_read))
        else $error("Memory read and write in the same cycle");

    // Only reset or run low may release HALT
    assert property (@(posedge clk) disable iff (ireg_reset)
        halted && run |=> halted)
        else $error("halted dropped while run stayed high");

endmodule

bind sequencer cpu_chk u_cpu_chk (.*);

`default_nettype wire

// File: tb_cpu.sv
// Testbench for the accumulator processor
// Assembles small programs into an image, loads them through the host
// port with run low, runs each to HALT and checks memory via the peek port
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

    localparam int period_ns   = 100;
    localparam int max_cycles  = 300;                   // Per program
    localparam int watchdog_ns = 12 * max_cycles * period_ns;

    logic       clk        = 1'b0;
    logic       ireg_reset = 1'b1;
    logic       run        = 1'b0;
    logic       host_we    = 1'b0;
    logic [7:0] host_addr  = '0;
    logic [7:0] host_wdata = '0;
    logic [7:0] peek_addr  = '0;
    logic [7:0] peek_data;
    logic       halted;

    logic [7:0] image [256];                            // Program and data image
    int         asm_pc;
    int         image_top;                              // One past highest byte in use
    int         error_count = 0;
    int         check_count = 0;

    cpu_top u_cpu_top (.*);

    always #(period_ns / 2) clk = ~clk;

    function automatic logic [7:0] expected_alu(logic [7:0] op, logic [7:0] a, logic [7:0] b);
        case (op)
            isa_pkg::op_add: return a + b;              // Modulo 256
            isa_pkg::op_sub: return a - b;
            isa_pkg::op_and: return a & b;
            isa_pkg::op_or:  return a | b;
            default:         return a ^ b;
        endcase
    endfunction

    task automatic new_program();
        for (int i = 0; i < 256; i++) begin
            image[i] = 8'(i) ^ 8'h5A;                   // Background differs per address
        end
        asm_pc    = 0;
        image_top = 0;
    endtask

    task automatic set_data(input int addr, input logic [7:0] val);
        image[addr] = val;
        if (addr + 1 > image_top) image_top = addr + 1;
    endtask

    task automatic emit(input logic [7:0] val);
        set_data(asm_pc, val);
        asm_pc++;
    endtask

    task automatic emit_imm(input logic [7:0] op, input logic [7:0] val);
        emit(op);
        emit(val);
    endtask

    task automatic emit_store(input int addr, input logic [7:0] val);
        emit_imm(isa_pkg::op_ldai, val);
        emit_imm(isa_pkg::op_ldli, 8'(addr));
        emit(isa_pkg::op_sta_hl);
    endtask

    // Target low byte is filled in later by patch_target
    task automatic emit_branch(input logic [7:0] op, output int pos);
        emit(op);
        emit(8'h00);
        pos = asm_pc;
        emit(8'h00);
    endtask

    task automatic patch_target(input int pos);
        image[pos] = 8'(asm_pc);
    endtask

    task automatic load_program();
        for (int i = 0; i < image_top; i++) begin
            @(posedge clk);
            #1;
            host_we    = 1'b1;
            host_addr  = 8'(i);
            host_wdata = image[i];
        end
        @(posedge clk);
        #1;
        host_we = 1'b0;
    endtask

    task automatic run_until_halt();
        int n;
        n = 0;
        @(posedge clk);
        #1;
        run = 1'b1;
        @(negedge clk);
        while (halted !== 1'b1 && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        check_count++;
        if (halted !== 1'b1) begin
            $display("Program did not reach HALT within %0d cycles at %0t", max_cycles, $time);
            error_count++;
        end
    endtask

    task automatic stop_run();
        @(posedge clk);
        #1;
        run = 1'b0;
    endtask

    task automatic check_byte(input int addr, input logic [7:0] expected);
        @(posedge clk);
        #1;
        peek_addr = 8'(addr);
        @(negedge clk);
        check_count++;
        if (peek_data !== expected) begin
            $display("Error at %0t: mem[%02h] = %02h, expected %02h",
                     $time, addr, peek_data, expected);
            error_count++;
        end
    endtask

    task automatic test_imm_store();
        logic [7:0] k;
        logic [7:0] v;
        k = 8'h80 + 8'($urandom % 32);
        v = 8'($urandom);
        new_program();
        set_data(k, ~v);
        emit_imm(isa_pkg::op_ldhi, 8'h00);
        emit_imm(isa_pkg::op_ldli, k);
        emit_imm(isa_pkg::op_ldai, v);
        emit(isa_pkg::op_sta_hl);
        emit(isa_pkg::op_halt);
        load_program();
        run_until_halt();
        stop_run();
        check_byte(k, v);
    endtask

    task automatic test_alu_ops();
        logic [7:0] ops [5];
        logic [7:0] results [6];
        logic [7:0] a;
        logic [7:0] b;
        ops = '{isa_pkg::op_add, isa_pkg::op_sub, isa_pkg::op_and,
                isa_pkg::op_or, isa_pkg::op_xor};
        for (int o = 0; o < 5; o++) begin
            new_program();
            emit_imm(isa_pkg::op_ldhi, 8'h00);
            for (int j = 0; j < 6; j++) begin
                a = 8'($urandom);
                b = 8'($urandom);
                results[j] = expected_alu(ops[o], a, b);
                set_data('h80 + j, ~results[j]);        // Stale value never matches
                emit_imm(isa_pkg::op_ldai, a);
                emit_imm(isa_pkg::op_ldbi, b);
                emit(ops[o]);
                emit_store_a('h80 + j);
            end
            emit(isa_pkg::op_halt);
            load_program();
            run_until_halt();
            stop_run();
            for (int j = 0; j < 6; j++) check_byte('h80 + j, results[j]);
        end
    endtask

    // Stores A as it stands without reloading it
    task automatic emit_store_a(input int addr);
        emit_imm(isa_pkg::op_ldli, 8'(addr));
        emit(isa_pkg::op_sta_hl);
    endtask

    task automatic test_indirect_mov();
        logic [7:0] v;
        v = 8'hA0 + 8'($urandom % 16);                  // Value doubles as an address
        new_program();
        set_data('h90, v);
        set_data('h98, ~v);
        set_data(v, ~v);
        emit_imm(isa_pkg::op_ldhi, 8'h00);
        emit_imm(isa_pkg::op_ldli, 8'h90);
        emit(isa_pkg::op_lda_hl);
        emit(isa_pkg::op_mov_ab);
        emit_imm(isa_pkg::op_ldai, ~v);                 // Clobber A
        emit(isa_pkg::op_mov_ba);
        emit_store_a('h98);
        emit(isa_pkg::op_mov_al);
        emit(isa_pkg::op_sta_hl);
        emit(isa_pkg::op_halt);
        load_program();
        run_until_halt();
        stop_run();
        check_byte('h90, v);
        check_byte('h98, v);
        check_byte(v, v);
    endtask

    task automatic test_branches();
        logic [7:0] x;
        logic [7:0] y;
        int t1;
        int t2;
        int t3;
        int t4;
        x = 8'($urandom);
        y = x ^ 8'(1 + $urandom % 255);                 // Never equal to x
        new_program();
        for (int i = 'hB0; i < 'hB5; i++) set_data(i, 8'h00);
        emit_imm(isa_pkg::op_ldhi, 8'h00);
        emit_imm(isa_pkg::op_ldai, x);
        emit_imm(isa_pkg::op_ldbi, x);
        emit(isa_pkg::op_xor);                          // Z set
        emit_branch(isa_pkg::op_jz, t1);
        emit_store('hB0, 8'h11);
        patch_target(t1);
        emit_store('hB1, 8'h22);
        emit_imm(isa_pkg::op_ldai, x);
        emit_imm(isa_pkg::op_ldbi, y);
        emit(isa_pkg::op_xor);                          // Z clear
        emit_branch(isa_pkg::op_jz, t2);
        emit_store('hB2, 8'h33);
        emit_branch(isa_pkg::op_jmp, t3);
        patch_target(t2);
        emit_store('hB3, 8'h44);
        patch_target(t3);
        emit_branch(isa_pkg::op_jmp, t4);
        emit_store('hB4, 8'h55);
        patch_target(t4);
        emit(isa_pkg::op_halt);
        load_program();
        run_until_halt();
        stop_run();
        check_byte('hB0, 8'h00);
        check_byte('hB1, 8'h22);
        check_byte('hB2, 8'h33);
        check_byte('hB3, 8'h00);
        check_byte('hB4, 8'h00);
    endtask

    task automatic test_halt_host();
        logic [7:0] v;
        v = 8'($urandom);
        new_program();
        set_data('h98, ~v);
        emit_imm(isa_pkg::op_ldhi, 8'h00);
        emit_imm(isa_pkg::op_ldli, 8'h98);
        emit_imm(isa_pkg::op_ldai, v);
        emit(isa_pkg::op_sta_hl);
        emit(isa_pkg::op_halt);
        load_program();
        run_until_halt();
        image['h98] = v;
        for (int n = 0; n < 20; n++) begin
            @(negedge clk);
            check_count++;
            if (halted !== 1'b1) begin
                $display("Error at %0t: halted low %0d cycles after HALT", $time, n + 1);
                error_count++;
            end
        end
        @(posedge clk);
        #1;
        host_we    = 1'b1;                              // Dropped while the processor owns memory
        host_addr  = 8'h97;
        host_wdata = ~image['h97];
        @(posedge clk);
        #1;
        host_we = 1'b0;
        for (int i = 0; i < image_top; i++) check_byte(i, image[i]);
        stop_run();
        repeat (2) @(negedge clk);
        check_count++;
        if (halted !== 1'b0) begin
            $display("Error at %0t: halted still high with run low", $time);
            error_count++;
        end
        image['h97] = ~image['h97];
        @(posedge clk);
        #1;
        host_we    = 1'b1;
        host_addr  = 8'h97;
        host_wdata = image['h97];
        @(posedge clk);
        #1;
        host_we = 1'b0;
        check_byte('h97, image['h97]);
    endtask

    initial begin
        void'($urandom(66));
        repeat (5) @(posedge clk);
        #1;
        ireg_reset = 1'b0;
        test_imm_store();
        test_alu_ops();
        test_indirect_mov();
        test_branches();
        test_halt_host();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout: tests did not finish within %0d ns", watchdog_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
isa_pkg.sv
uarch_pkg.sv
alu.sv
bus_select.sv
program_counter.sv
register_bank.sv
sequencer.sv
shared_ram.sv
cpu_top.sv
cpu_chk.sv
tb_cpu.sv
